//--- source/trace_obs_macros.svh
`ifndef TRACE_OBS_MACROS_SVH
`define TRACE_OBS_MACROS_SVH

// Observed cores and width of a core index
`define TRACE_OBS_NUM_CORES 4
`define TRACE_OBS_CORE_W 2

// Entries per event FIFO
`define TRACE_OBS_FIFO_DEPTH 8

// Upper half-word of l.nop
`define TRACE_OBS_NOP_OPCODE 16'h1500

// Simulation-control immediates
`define TRACE_OBS_NOP_EXIT 16'h0001
`define TRACE_OBS_NOP_REPORT 16'h0002
`define TRACE_OBS_NOP_PUTC 16'h0004

// Host register byte offsets
`define TRACE_OBS_REG_STATUS 8'h00
`define TRACE_OBS_REG_CHAR 8'h04
`define TRACE_OBS_REG_REPORT_ID 8'h08
`define TRACE_OBS_REG_REPORT_DATA 8'h0C
// One exit code word per core from here on
`define TRACE_OBS_REG_EXIT_BASE 8'h10

`endif

//--- source/trace_obs_pkg.sv
`default_nettype none

`include "trace_obs_macros.svh"

package trace_obs_pkg;

   // Index of an observed core
   typedef logic [`TRACE_OBS_CORE_W-1:0] core_id_t;

   // Character from l.nop 4, 10 bits
   typedef struct packed {
      core_id_t core;
      logic [7:0] ch;
   } char_event_t;

   // Value from l.nop 2, 34 bits
   typedef struct packed {
      core_id_t core;
      logic [31:0] value;
   } report_event_t;

   // Kind of event held in a pending slot
   typedef enum logic {
      putc = 1'b0,
      report = 1'b1
   } event_kind_t;

endpackage

`default_nettype wire

//--- source/r3_shadow.sv
`default_nettype none
`timescale 1ns/10ps

module r3_shadow (
   input wire clk,
   input wire rst,
   // Trace write-back of one core
   input wire valid,
   input wire wben,
   input wire [4:0] wbreg,
   input wire [31:0] wbdata,
   // Shadow copy of r3
   output logic [31:0] r3
);

   logic r3_write;

   // Only retired beats that write back r3
   assign r3_write = valid && wben && (wbreg == 5'd3);

   // New value visible from the next cycle
   always_ff @(posedge clk) begin
      if (rst) begin
         r3 <= '0;
      end else if (r3_write) begin
         r3 <= wbdata;
      end
   end

   // Register index must be known whenever a write-back is signalled
   assert property (
      @(posedge clk) disable iff (rst)
      (valid && wben) |-> !$isunknown(wbreg)
   );

endmodule

`default_nettype wire

//--- source/nop_event_decoder.sv
`default_nettype none
`timescale 1ns/10ps

`include "trace_obs_macros.svh"

module nop_event_decoder (
   input wire clk,
   input wire rst,
   // Trace beat and shadow r3 of one core
   input wire valid,
   input wire [31:0] insn,
   input wire [31:0] r3,
   // Slot is taken by the arbiter
   input wire grant,
   output logic pending,
   output trace_obs_pkg::event_kind_t kind,
   output logic [31:0] value,
   output logic exited,
   output logic [31:0] exit_code,
   output logic overflow,
   input wire overflow_clr
);

   logic is_nop;
   logic exit_q;
   logic putc_q;
   logic report_q;
   logic accept;

   assign is_nop = valid && (insn[31:16] == `TRACE_OBS_NOP_OPCODE);

   // Slot free, or freed by this cycle's grant
   assign accept = (putc_q || report_q) && (!pending || grant);

   always_ff @(posedge clk) begin
      if (rst) begin
         exit_q <= 1'b0;
         putc_q <= 1'b0;
         report_q <= 1'b0;
         pending <= 1'b0;
         exited <= 1'b0;
         exit_code <= '0;
         overflow <= 1'b0;
      end else begin
         // Decoded nop held one cycle so r3 is settled
         exit_q <= is_nop && (insn[15:0] == `TRACE_OBS_NOP_EXIT);
         putc_q <= is_nop && (insn[15:0] == `TRACE_OBS_NOP_PUTC);
         report_q <= is_nop && (insn[15:0] == `TRACE_OBS_NOP_REPORT);
         if (grant) begin
            pending <= 1'b0;
         end
         if (accept) begin
            pending <= 1'b1;
         end
         // Exit bypasses the slot
         if (exit_q) begin
            exited <= 1'b1;
            exit_code <= r3;
         end
         if (overflow_clr) begin
            overflow <= 1'b0;
         end
         // Dropped event wins over a clear in the same cycle
         if ((putc_q || report_q) && !accept) begin
            overflow <= 1'b1;
         end
      end
   end

   // Slot payload
   always_ff @(posedge clk) begin
      if (accept) begin
         kind <= putc_q ? trace_obs_pkg::putc : trace_obs_pkg::report;
         value <= putc_q ? {24'h0, r3[7:0]} : r3;
      end
   end

   // Arbiter only takes a filled slot
   assert property (@(posedge clk) disable iff (rst) grant |-> pending);

endmodule

`default_nettype wire

//--- source/event_arbiter.sv
`default_nettype none
`timescale 1ns/10ps

`include "trace_obs_macros.svh"

module event_arbiter (
   input wire clk,
   input wire rst,
   // Pending slots of all cores
   input wire [`TRACE_OBS_NUM_CORES-1:0] pending,
   input wire trace_obs_pkg::event_kind_t [`TRACE_OBS_NUM_CORES-1:0] kind,
   input wire [`TRACE_OBS_NUM_CORES-1:0][31:0] value,
   input wire char_full,
   input wire report_full,
   output logic [`TRACE_OBS_NUM_CORES-1:0] grant,
   output logic char_push,
   output trace_obs_pkg::char_event_t char_data,
   output logic report_push,
   output trace_obs_pkg::report_event_t report_data
);

   localparam int N = `TRACE_OBS_NUM_CORES;

   logic [N-1:0] eligible;
   trace_obs_pkg::core_id_t last_q;
   trace_obs_pkg::core_id_t sel;
   logic found;

   // Core may go only if its target FIFO has room
   always_comb begin
      for (int i = 0; i < N; i++) begin
         if (kind[i] == trace_obs_pkg::putc) begin
            eligible[i] = pending[i] && !char_full;
         end else begin
            eligible[i] = pending[i] && !report_full;
         end
      end
   end

   // Search starts one past the last winner
   always_comb begin
      int idx;
      grant = '0;
      sel = last_q;
      found = 1'b0;
      for (int k = 1; k <= N; k++) begin
         idx = (int'(last_q) + k) % N;
         if (!found && eligible[idx]) begin
            found = 1'b1;
            sel = trace_obs_pkg::core_id_t'(idx);
         end
      end
      if (found) begin
         grant[sel] = 1'b1;
      end
   end

   // Push in the grant cycle
   always_comb begin
      char_push = found && (kind[sel] == trace_obs_pkg::putc);
      report_push = found && (kind[sel] == trace_obs_pkg::report);
      char_data.core = sel;
      char_data.ch = value[sel][7:0];
      report_data.core = sel;
      report_data.value = value[sel];
   end

   // Core 0 first after reset
   always_ff @(posedge clk) begin
      if (rst) begin
         last_q <= trace_obs_pkg::core_id_t'(N - 1);
      end else if (found) begin
         last_q <= sel;
      end
   end

   // A slot that loses arbitration stays filled
   assert property (
      @(posedge clk) disable iff (rst)
      |(pending & ~grant) |=> (($past(pending & ~grant) & ~pending) == '0)
   );

endmodule

`default_nettype wire

//--- source/event_fifo.sv
`default_nettype none
`timescale 1ns/10ps

`include "trace_obs_macros.svh"

module event_fifo #(
   parameter type payload_t = logic [31:0],
   parameter int DEPTH = `TRACE_OBS_FIFO_DEPTH
) (
   input wire clk,
   input wire rst,
   input wire push,
   input wire payload_t data_in,
   input wire pop,
   output payload_t data_out,
   output logic empty,
   output logic full
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   payload_t mem [DEPTH];
   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W-1:0] wr_ptr;
   logic [CNT_W-1:0] count;
   logic do_push;
   logic do_pop;

   assign do_push = push && !full;
   assign do_pop = pop && !empty;
   assign empty = (count == '0);
   assign full = (count == CNT_W'(DEPTH));

   // Head valid while not empty
   assign data_out = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= data_in;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         count <= '0;
      end else begin
         // Pointers wrap at DEPTH, not at a power of two
         if (do_push) begin
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10: count <= count + 1'b1;
            2'b01: count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Writer and reader must respect the flags
   assert property (@(posedge clk) disable iff (rst) push |-> !full);
   assert property (@(posedge clk) disable iff (rst) pop |-> !empty);

endmodule

`default_nettype wire

//--- source/trace_obs_wb_regs.sv
`default_nettype none
`timescale 1ns/10ps

`include "trace_obs_macros.svh"

module trace_obs_wb_regs (
   input wire clk,
   input wire rst,
   // Wishbone classic slave
   input wire wb_cyc,
   input wire wb_stb,
   input wire wb_we,
   input wire [7:0] wb_adr,
   input wire [31:0] wb_dat_w,
   output logic [31:0] wb_dat_r,
   output logic wb_ack,
   // Per-core state
   input wire [`TRACE_OBS_NUM_CORES-1:0] exited,
   input wire [`TRACE_OBS_NUM_CORES-1:0][31:0] exit_code,
   input wire [`TRACE_OBS_NUM_CORES-1:0] overflow,
   // FIFO heads
   input wire trace_obs_pkg::char_event_t char_data,
   input wire char_empty,
   input wire trace_obs_pkg::report_event_t report_data,
   input wire report_empty,
   output logic char_pop,
   output logic report_pop,
   output logic [`TRACE_OBS_NUM_CORES-1:0] overflow_clr
);

   localparam int N = `TRACE_OBS_NUM_CORES;

   logic req;
   logic [7:0] exit_off;
   logic [31:0] rd_data;

   // New access, not the ack cycle of the previous one
   assign req = wb_cyc && wb_stb && !wb_ack;
   assign exit_off = wb_adr - `TRACE_OBS_REG_EXIT_BASE;

   always_comb begin
      rd_data = '0;
      case (wb_adr)
         `TRACE_OBS_REG_STATUS: begin
            rd_data[N-1:0] = exited;
            // All exited
            rd_data[4] = &exited;
            rd_data[8 +: N] = overflow;
            rd_data[16] = !char_empty;
            rd_data[17] = !report_empty;
         end
         `TRACE_OBS_REG_CHAR: begin
            rd_data[31] = !char_empty;
            if (!char_empty) begin
               rd_data[8 +: `TRACE_OBS_CORE_W] = char_data.core;
               rd_data[7:0] = char_data.ch;
            end
         end
         `TRACE_OBS_REG_REPORT_ID: begin
            rd_data[31] = !report_empty;
            rd_data[`TRACE_OBS_CORE_W-1:0] = report_data.core;
         end
         `TRACE_OBS_REG_REPORT_DATA: rd_data = report_data.value;
         default: begin
            // Exit code window, zero elsewhere
            for (int n = 0; n < N; n++) begin
               if ((wb_adr >= `TRACE_OBS_REG_EXIT_BASE) && (exit_off[7:2] == n)) begin
                  rd_data = exit_code[n];
               end
            end
         end
      endcase
   end

   // Ack, pops and clears all land in the ack cycle
   always_ff @(posedge clk) begin
      if (rst) begin
         wb_ack <= 1'b0;
         char_pop <= 1'b0;
         report_pop <= 1'b0;
         overflow_clr <= '0;
      end else begin
         wb_ack <= req;
         char_pop <= req && !wb_we && (wb_adr == `TRACE_OBS_REG_CHAR) && !char_empty;
         report_pop <= req && !wb_we && (wb_adr == `TRACE_OBS_REG_REPORT_DATA)
                       && !report_empty;
         if (req && wb_we && (wb_adr == `TRACE_OBS_REG_STATUS)) begin
            overflow_clr <= wb_dat_w[8 +: N];
         end else begin
            overflow_clr <= '0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (req) begin
         wb_dat_r <= rd_data;
      end
   end

   // Host holds the request steady until ack
   assert property (
      @(posedge clk) disable iff (rst)
      (wb_cyc && wb_stb && !wb_ack)
         |=> (wb_cyc && wb_stb && $stable(wb_adr) && $stable(wb_we))
   );

endmodule

`default_nettype wire

//--- source/trace_obs_top.sv
`default_nettype none
`timescale 1ns/10ps

`include "trace_obs_macros.svh"

module trace_obs_top (
   input wire clk,
   input wire rst,
   // Trace beats, packed over cores
   input wire [`TRACE_OBS_NUM_CORES-1:0] trace_valid,
   input wire [`TRACE_OBS_NUM_CORES-1:0][31:0] trace_insn,
   input wire [`TRACE_OBS_NUM_CORES-1:0] trace_wben,
   input wire [`TRACE_OBS_NUM_CORES-1:0][4:0] trace_wbreg,
   input wire [`TRACE_OBS_NUM_CORES-1:0][31:0] trace_wbdata,
   // Host side
   input wire wb_cyc,
   input wire wb_stb,
   input wire wb_we,
   input wire [7:0] wb_adr,
   input wire [31:0] wb_dat_w,
   output logic [31:0] wb_dat_r,
   output logic wb_ack
);

   localparam int N = `TRACE_OBS_NUM_CORES;

   logic [N-1:0][31:0] r3;
   logic [N-1:0] pending;
   trace_obs_pkg::event_kind_t [N-1:0] kind;
   logic [N-1:0][31:0] value;
   logic [N-1:0] grant;
   logic [N-1:0] exited;
   logic [N-1:0][31:0] exit_code;
   logic [N-1:0] overflow;
   logic [N-1:0] overflow_clr;
   logic char_push;
   logic char_pop;
   logic char_empty;
   logic char_full;
   logic report_push;
   logic report_pop;
   logic report_empty;
   logic report_full;
   trace_obs_pkg::char_event_t char_in;
   trace_obs_pkg::char_event_t char_head;
   trace_obs_pkg::report_event_t report_in;
   trace_obs_pkg::report_event_t report_head;

   // Shadow and decoder per core
   for (genvar i = 0; i < N; i++) begin : gen_core
      r3_shadow r3_shadow_i (
         .clk(clk), .rst(rst), .valid(trace_valid[i]), .wben(trace_wben[i]),
         .wbreg(trace_wbreg[i]), .wbdata(trace_wbdata[i]), .r3(r3[i])
      );
      nop_event_decoder nop_event_decoder_i (
         .clk(clk), .rst(rst), .valid(trace_valid[i]), .insn(trace_insn[i]),
         .r3(r3[i]), .grant(grant[i]), .pending(pending[i]), .kind(kind[i]),
         .value(value[i]), .exited(exited[i]), .exit_code(exit_code[i]),
         .overflow(overflow[i]), .overflow_clr(overflow_clr[i])
      );
   end

   event_arbiter event_arbiter_i (
      .clk(clk), .rst(rst), .pending(pending), .kind(kind), .value(value),
      .char_full(char_full), .report_full(report_full), .grant(grant),
      .char_push(char_push), .char_data(char_in),
      .report_push(report_push), .report_data(report_in)
   );

   // One FIFO per event kind
   event_fifo #(.payload_t(trace_obs_pkg::char_event_t)) char_fifo_i (
      .clk(clk), .rst(rst), .push(char_push), .data_in(char_in), .pop(char_pop),
      .data_out(char_head), .empty(char_empty), .full(char_full)
   );
   event_fifo #(.payload_t(trace_obs_pkg::report_event_t)) report_fifo_i (
      .clk(clk), .rst(rst), .push(report_push), .data_in(report_in), .pop(report_pop),
      .data_out(report_head), .empty(report_empty), .full(report_full)
   );

   trace_obs_wb_regs trace_obs_wb_regs_i (
      .clk(clk), .rst(rst), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
      .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
      .exited(exited), .exit_code(exit_code), .overflow(overflow),
      .char_data(char_head), .char_empty(char_empty),
      .report_data(report_head), .report_empty(report_empty),
      .char_pop(char_pop), .report_pop(report_pop), .overflow_clr(overflow_clr)
   );

endmodule

`default_nettype wire

//--- tests/tb_trace_obs.sv
`default_nettype none
`timescale 1ns/10ps

`include "trace_obs_macros.svh"

module tb_trace_obs;

   localparam int N = `TRACE_OBS_NUM_CORES;
   localparam int ACK_TIMEOUT = 16;
   localparam int POLL_LIMIT = 64;
   // Any instruction outside the l.nop encoding
   localparam logic [31:0] INSN_ALU = 32'he000_0000;

   logic clk = 1'b0;
   logic rst;
   logic [N-1:0] trace_valid;
   logic [N-1:0][31:0] trace_insn;
   logic [N-1:0] trace_wben;
   logic [N-1:0][4:0] trace_wbreg;
   logic [N-1:0][31:0] trace_wbdata;
   logic wb_cyc;
   logic wb_stb;
   logic wb_we;
   logic [7:0] wb_adr;
   logic [31:0] wb_dat_w;
   logic [31:0] wb_dat_r;
   logic wb_ack;

   int mismatches = 0;
   int timeouts = 0;
   int seed_ret;

   trace_obs_top trace_obs_top_i (
      .clk(clk), .rst(rst),
      .trace_valid(trace_valid), .trace_insn(trace_insn), .trace_wben(trace_wben),
      .trace_wbreg(trace_wbreg), .trace_wbdata(trace_wbdata),
      .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
      .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
   );

   // 20 ns period
   always #10 clk = ~clk;

   task automatic compare_word(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
      if (got !== exp) begin
         $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
         mismatches++;
      end
   endtask

   // Single classic read, ack sampled before the edge
   task automatic wb_read(input logic [7:0] adr, output logic [31:0] data);
      int cycles;
      cycles = 0;
      data = '0;
      @(posedge clk);
      wb_cyc <= 1'b1;
      wb_stb <= 1'b1;
      wb_we <= 1'b0;
      wb_adr <= adr;
      do begin
         @(posedge clk);
         cycles++;
      end while (!wb_ack && cycles < ACK_TIMEOUT);
      if (wb_ack) begin
         data = wb_dat_r;
      end else begin
         $display("Timeout: no ack for the read of address 0x%h", adr);
         timeouts++;
      end
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
   endtask

   task automatic wb_write(input logic [7:0] adr, input logic [31:0] data);
      int cycles;
      cycles = 0;
      @(posedge clk);
      wb_cyc <= 1'b1;
      wb_stb <= 1'b1;
      wb_we <= 1'b1;
      wb_adr <= adr;
      wb_dat_w <= data;
      do begin
         @(posedge clk);
         cycles++;
      end while (!wb_ack && cycles < ACK_TIMEOUT);
      if (!wb_ack) begin
         $display("Timeout: no ack for the write to address 0x%h", adr);
         timeouts++;
      end
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we <= 1'b0;
   endtask

   // Re-read STATUS until the masked bits match
   task automatic wait_status(input logic [31:0] mask, input logic [31:0] value,
                              input string what);
      logic [31:0] status;
      int polls;
      polls = 0;
      wb_read(`TRACE_OBS_REG_STATUS, status);
      while (((status & mask) != value) && polls < POLL_LIMIT) begin
         wb_read(`TRACE_OBS_REG_STATUS, status);
         polls++;
      end
      if ((status & mask) != value) begin
         $display("Timeout: STATUS never showed %s", what);
         timeouts++;
      end
   endtask

   // One beat on one core, then idle
   task automatic trace_beat(input int core, input logic valid, input logic [31:0] insn,
                             input logic wben, input logic [4:0] wbreg,
                             input logic [31:0] wbdata);
      @(posedge clk);
      trace_valid[core] <= valid;
      trace_insn[core] <= insn;
      trace_wben[core] <= wben;
      trace_wbreg[core] <= wbreg;
      trace_wbdata[core] <= wbdata;
      @(posedge clk);
      trace_valid[core] <= 1'b0;
      trace_wben[core] <= 1'b0;
   endtask

   task automatic trace_write_r3(input int core, input logic [31:0] data);
      trace_beat(core, 1'b1, INSN_ALU, 1'b1, 5'd3, data);
   endtask

   // Same l.nop on every core in the mask, same cycle
   task automatic trace_nop(input logic [N-1:0] mask, input logic [15:0] code);
      @(posedge clk);
      for (int c = 0; c < N; c++) begin
         if (mask[c]) begin
            trace_valid[c] <= 1'b1;
            trace_insn[c] <= {`TRACE_OBS_NOP_OPCODE, code};
            trace_wben[c] <= 1'b0;
         end
      end
      @(posedge clk);
      trace_valid <= '0;
   endtask

   task automatic putc_single();
      logic [31:0] val;
      logic [31:0] rdata;
      val = $urandom();
      trace_write_r3(2, val);
      trace_nop(4'b0100, `TRACE_OBS_NOP_PUTC);
      wait_status(32'h0001_0000, 32'h0001_0000, "a character");
      wb_read(`TRACE_OBS_REG_CHAR, rdata);
      compare_word("CHAR", rdata, {1'b1, 21'b0, 2'd2, val[7:0]});
      // Popped, so nothing left
      wb_read(`TRACE_OBS_REG_CHAR, rdata);
      compare_word("CHAR[31]", {31'b0, rdata[31]}, 32'h0);
   endtask

   task automatic report_all_cores();
      logic [31:0] vals [N];
      logic [31:0] tmp;
      logic [31:0] id;
      logic [31:0] data;
      logic [N-1:0] seen;
      int c;
      seen = '0;
      // Core index in the top bits keeps the values distinct
      for (int i = 0; i < N; i++) begin
         tmp = $urandom();
         vals[i] = {2'(i), tmp[29:0]};
         trace_write_r3(i, vals[i]);
      end
      trace_nop('1, `TRACE_OBS_NOP_REPORT);
      for (int k = 0; k < N; k++) begin
         wait_status(32'h0002_0000, 32'h0002_0000, "a report");
         wb_read(`TRACE_OBS_REG_REPORT_ID, id);
         compare_word("REPORT_ID[31]", {31'b0, id[31]}, 32'h1);
         c = int'(id[1:0]);
         if (seen[c]) begin
            $display("Core %0d was reported more than once", c);
            mismatches++;
         end
         seen[c] = 1'b1;
         wb_read(`TRACE_OBS_REG_REPORT_DATA, data);
         compare_word("REPORT_DATA", data, vals[c]);
      end
      compare_word("reported cores", 32'(seen), 32'(4'hf));
   endtask

   task automatic exit_all_cores();
      logic [31:0] codes [N];
      logic [31:0] status;
      logic [31:0] rdata;
      for (int c = 0; c < N - 1; c++) begin
         codes[c] = $urandom();
         trace_write_r3(c, codes[c]);
         trace_nop(4'(1 << c), `TRACE_OBS_NOP_EXIT);
      end
      wait_status(32'h7, 32'h7, "the exit of cores 0 to 2");
      wb_read(`TRACE_OBS_REG_STATUS, status);
      compare_word("STATUS[4]", {31'b0, status[4]}, 32'h0);
      for (int c = 0; c < N - 1; c++) begin
         wb_read(`TRACE_OBS_REG_EXIT_BASE + 8'(4 * c), rdata);
         compare_word("EXIT_CODE", rdata, codes[c]);
      end
      // Last core completes the set
      codes[3] = $urandom();
      trace_write_r3(3, codes[3]);
      trace_nop(4'b1000, `TRACE_OBS_NOP_EXIT);
      wait_status(32'h8, 32'h8, "the exit of core 3");
      wb_read(`TRACE_OBS_REG_STATUS, status);
      compare_word("STATUS[4]", {31'b0, status[4]}, 32'h1);
      wb_read(`TRACE_OBS_REG_EXIT_BASE + 8'd12, rdata);
      compare_word("EXIT_CODE", rdata, codes[3]);
   endtask

   task automatic putc_overflow();
      logic [7:0] chars [$];
      logic [31:0] val;
      logic [31:0] rdata;
      logic [31:0] status;
      // Putc beats every 4 cycles, host idle
      for (int i = 0; i < 10; i++) begin
         val = $urandom();
         chars.push_back(val[7:0]);
         trace_write_r3(1, val);
         trace_nop(4'b0010, `TRACE_OBS_NOP_PUTC);
      end
      wait_status(32'h0000_0200, 32'h0000_0200, "the overflow of core 1");
      // 8 in the FIFO plus 1 in the slot
      for (int i = 0; i < 9; i++) begin
         wb_read(`TRACE_OBS_REG_CHAR, rdata);
         compare_word("CHAR", rdata, {1'b1, 21'b0, 2'd1, chars[i]});
      end
      wb_read(`TRACE_OBS_REG_CHAR, rdata);
      compare_word("CHAR[31]", {31'b0, rdata[31]}, 32'h0);
      wb_write(`TRACE_OBS_REG_STATUS, 32'h0000_0200);
      wb_read(`TRACE_OBS_REG_STATUS, status);
      compare_word("STATUS[9]", {31'b0, status[9]}, 32'h0);
   endtask

   task automatic shadow_write_rules();
      logic [31:0] base;
      logic [31:0] rdata;
      base = $urandom();
      // r3, then a later wrong register, then a beat with valid low
      trace_write_r3(0, base);
      trace_beat(0, 1'b1, INSN_ALU, 1'b1, 5'd5, base ^ 32'h1);
      trace_beat(0, 1'b0, {`TRACE_OBS_NOP_OPCODE, `TRACE_OBS_NOP_PUTC}, 1'b1, 5'd3,
                 base ^ 32'h2);
      trace_nop(4'b0001, `TRACE_OBS_NOP_PUTC);
      wait_status(32'h0001_0000, 32'h0001_0000, "a character");
      wb_read(`TRACE_OBS_REG_CHAR, rdata);
      compare_word("CHAR", rdata, {1'b1, 21'b0, 2'd0, base[7:0]});
      // Invalid putc left no event
      wb_read(`TRACE_OBS_REG_CHAR, rdata);
      compare_word("CHAR[31]", {31'b0, rdata[31]}, 32'h0);
   endtask

   initial begin
      seed_ret = $urandom(32'ha94d_8dd0);
      rst <= 1'b1;
      trace_valid <= '0;
      trace_insn <= '0;
      trace_wben <= '0;
      trace_wbreg <= '0;
      trace_wbdata <= '0;
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we <= 1'b0;
      wb_adr <= '0;
      wb_dat_w <= '0;
      repeat (10) @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);
      putc_single();
      report_all_cores();
      exit_all_cores();
      putc_overflow();
      shadow_write_rules();
      repeat (2) @(posedge clk);
      $display("Checks done with %0d mismatches and %0d timeouts", mismatches, timeouts);
      if (mismatches == 0 && timeouts == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- trace_obs.f
+incdir+source
source/trace_obs_pkg.sv
source/r3_shadow.sv
source/nop_event_decoder.sv
source/event_arbiter.sv
source/event_fifo.sv
source/trace_obs_wb_regs.sv
source/trace_obs_top.sv
tests/tb_trace_obs.sv

//--- Bender.yml
package:
  name: trace_obs

sources:
  - include_dirs:
      - source
    files:
      - source/trace_obs_pkg.sv
      - source/r3_shadow.sv
      - source/nop_event_decoder.sv
      - source/event_arbiter.sv
      - source/event_fifo.sv
      - source/trace_obs_wb_regs.sv
      - source/trace_obs_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - tests/tb_trace_obs.sv
